// ==== filelist.f ====
design/softmc_pkg.sv
design/dfi_cmd_if.sv
design/instr_queue.sv
design/iseq_executor.sv
design/refresh_engine.sv
design/cmd_arbiter.sv
design/rdback_fifo.sv
design/softmc_top.sv
tests/softmc_checker.sv
tests/tb_softmc.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_softmc -o tb_softmc

status=0
./obj_dir/tb_softmc > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation finished cleanly"

// ==== tests/tb_softmc.sv ====
`timescale 1ns/10ps

module tb_softmc;

	localparam logic [63:0] RD_TAG = 64'h5a5a_0000_0000_0000;
	localparam int BP_WAIT = 30;
	localparam int BP_LONG_WAIT = 150; // keeps the first sequence busy while the queue fills
	localparam int WAIT_SUM = 60 + BP_LONG_WAIT + (softmc_pkg::IQ_DEPTH - 1) * (BP_WAIT + 2);
	localparam int TEST_CYCLES = 10 + 5 * softmc_pkg::REF_INTERVAL + 400;
	localparam int WATCHDOG_CYCLES = TEST_CYCLES + WAIT_SUM + 1000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic app_en = 1'b0;
	softmc_pkg::instr_t app_instr = '0;
	logic rdback_fifo_rden = 1'b0;
	logic [softmc_pkg::DATA_W-1:0] dfi_rddata = '0;
	logic dfi_rddata_valid = 1'b0;

	logic app_ack;
	logic iq_full;
	logic processing_iseq;
	logic dfi_cs_n;
	logic dfi_ras_n;
	logic dfi_cas_n;
	logic dfi_we_n;
	logic [softmc_pkg::BANK_W-1:0] dfi_bank;
	logic [softmc_pkg::ROW_W-1:0] dfi_address;
	logic dfi_rddata_en;
	logic [softmc_pkg::DATA_W-1:0] rdback_data;
	logic rdback_fifo_empty;

	int cyc = 0;
	logic [31:0] lfsr = 32'hdb2d15b8;
	logic [2:0] en_pipe = '0;
	logic [softmc_pkg::DATA_W-1:0] word_pipe [3];

	softmc_pkg::ddr_cmd_t mon_cmd [$]; // non-refresh commands seen on the pins
	int mon_cyc [$];
	int ref_cyc [$];

	softmc_top dut0 (
		.clk(clk),
		.reset(reset),
		.app_en(app_en),
		.app_ack(app_ack),
		.app_instr(app_instr),
		.iq_full(iq_full),
		.processing_iseq(processing_iseq),
		.dfi_cs_n(dfi_cs_n),
		.dfi_ras_n(dfi_ras_n),
		.dfi_cas_n(dfi_cas_n),
		.dfi_we_n(dfi_we_n),
		.dfi_bank(dfi_bank),
		.dfi_address(dfi_address),
		.dfi_rddata_en(dfi_rddata_en),
		.dfi_rddata(dfi_rddata),
		.dfi_rddata_valid(dfi_rddata_valid),
		.rdback_fifo_rden(rdback_fifo_rden),
		.rdback_data(rdback_data),
		.rdback_fifo_empty(rdback_fifo_empty)
	);

	always #20 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic softmc_pkg::ddr_cmd_t cmd_of(logic [3:0] bits, logic [2:0] bank,
		logic [15:0] addr);
		return '{cs_n: bits[3], ras_n: bits[2], cas_n: bits[1], we_n: bits[0],
			bank: bank, address: addr};
	endfunction

	function automatic softmc_pkg::ddr_cmd_t pins_now();
		return '{cs_n: dfi_cs_n, ras_n: dfi_ras_n, cas_n: dfi_cas_n, we_n: dfi_we_n,
			bank: dfi_bank, address: dfi_address};
	endfunction

	function automatic logic [63:0] model_word(logic [2:0] bank, logic [15:0] addr);
		return RD_TAG | (64'(bank) << 16) | 64'(addr);
	endfunction

	function automatic softmc_pkg::instr_t ddr_word(softmc_pkg::ddr_cmd_t c);
		softmc_pkg::instr_t w;
		w = '0;
		w.ddr.op = softmc_pkg::INSTR_DDR;
		w.ddr.cs_n = c.cs_n;
		w.ddr.ras_n = c.ras_n;
		w.ddr.cas_n = c.cas_n;
		w.ddr.we_n = c.we_n;
		w.ddr.bank = c.bank;
		w.ddr.address = c.address;
		return w;
	endfunction

	function automatic softmc_pkg::instr_t wait_word(int n);
		softmc_pkg::instr_t w;
		w = '0;
		w.wt.op = softmc_pkg::INSTR_WAIT;
		w.wt.cycles = n[softmc_pkg::WAIT_W-1:0];
		return w;
	endfunction

	function automatic softmc_pkg::instr_t end_word();
		softmc_pkg::instr_t w;
		w = '0;
		w.ddr.op = softmc_pkg::INSTR_END;
		return w;
	endfunction

	// DRAM read model returns data four cycles after the read
	always @(posedge clk) begin
		en_pipe <= {en_pipe[1:0], dfi_rddata_en};
		word_pipe[0] <= model_word(dfi_bank, dfi_address);
		word_pipe[1] <= word_pipe[0];
		word_pipe[2] <= word_pipe[1];
		dfi_rddata_valid <= en_pipe[2];
		dfi_rddata <= word_pipe[2];
	end

	always @(negedge clk) begin
		if (!reset && !dfi_cs_n) begin
			if ({dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n} == softmc_pkg::CMD_REF_BITS) begin
				ref_cyc.push_back(cyc);
			end else begin
				mon_cmd.push_back(pins_now());
				mon_cyc.push_back(cyc);
			end
		end
	end

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_cmd(softmc_pkg::ddr_cmd_t got, softmc_pkg::ddr_cmd_t exp, string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_data(logic [softmc_pkg::DATA_W-1:0] got,
		logic [softmc_pkg::DATA_W-1:0] exp, string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(logic got, logic exp, string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp));
	endtask

	// four-phase push that returns once app_ack is low again
	task automatic push_word(softmc_pkg::instr_t w);
		@(posedge clk);
		app_en <= 1'b1;
		app_instr <= w;
		do @(negedge clk); while (!app_ack);
		@(posedge clk);
		app_en <= 1'b0;
		do @(negedge clk); while (app_ack);
	endtask

	task automatic wait_idle();
		int low_cycles;
		low_cycles = 0;
		while (low_cycles < 4) begin
			@(negedge clk);
			if (processing_iseq)
				low_cycles = 0;
			else
				low_cycles++;
		end
	endtask

	task automatic idle_after_reset();
		@(negedge clk);
		check_bit(app_ack, 1'b0, "app_ack after reset");
		check_bit(iq_full, 1'b0, "iq_full after reset");
		check_bit(processing_iseq, 1'b0, "processing_iseq after reset");
		check_bit(rdback_fifo_empty, 1'b1, "rdback_fifo_empty after reset");
		check_cmd(pins_now(), softmc_pkg::CMD_NOP, "DFI pins after reset");
		check_bit(dfi_rddata_en, 1'b0, "dfi_rddata_en after reset");
	endtask

	task automatic command_order();
		logic [3:0] bits [3];
		softmc_pkg::ddr_cmd_t exp [3];
		logic [2:0] bank;
		logic [15:0] addr;
		int base;
		bits[0] = 4'b0011; // ACT
		bits[1] = 4'b0100; // WRITE
		bits[2] = 4'b0010; // PRE
		base = mon_cmd.size();
		for (int i = 0; i < 3; i++) begin
			bank = 3'(take_bits(3));
			addr = 16'(take_bits(16));
			exp[i] = cmd_of(bits[i], bank, addr);
			push_word(ddr_word(exp[i]));
		end
		push_word(end_word());
		check_bit(processing_iseq, 1'b1, "processing_iseq after END stored");
		wait_idle();
		if (mon_cmd.size() != base + 3)
			abort_run($sformatf("[FAIL] %0t expected 3 commands, monitor saw %0d", $time,
				mon_cmd.size() - base));
		for (int i = 0; i < 3; i++)
			check_cmd(mon_cmd[base + i], exp[i], "command order");
	endtask

	task automatic wait_gap();
		softmc_pkg::ddr_cmd_t first;
		softmc_pkg::ddr_cmd_t second;
		logic [2:0] bank;
		logic [15:0] addr;
		int n;
		int base;
		int gap;
		bank = 3'(take_bits(3));
		addr = 16'(take_bits(16));
		first = cmd_of(4'b0011, bank, addr);
		bank = 3'(take_bits(3));
		addr = 16'(take_bits(16));
		second = cmd_of(4'b0010, bank, addr);
		n = 5 + int'(take_bits(6) % 32'd56); // 5 to 60
		base = mon_cmd.size();
		push_word(ddr_word(first));
		push_word(wait_word(n));
		push_word(ddr_word(second));
		push_word(end_word());
		wait_idle();
		if (mon_cmd.size() != base + 2)
			abort_run($sformatf("[FAIL] %0t expected 2 commands, monitor saw %0d", $time,
				mon_cmd.size() - base));
		check_cmd(mon_cmd[base], first, "command before WAIT");
		check_cmd(mon_cmd[base + 1], second, "command after WAIT");
		gap = mon_cyc[base + 1] - mon_cyc[base];
		if (gap < n + 3)
			abort_run($sformatf("[FAIL] %0t gap of %0d cycles around WAIT %0d, expected >= %0d",
				$time, gap, n, n + 3));
	endtask

	task automatic read_back();
		logic [63:0] exp [4];
		logic [2:0] bank;
		logic [15:0] addr;
		for (int i = 0; i < 4; i++) begin
			bank = 3'(take_bits(3));
			addr = 16'(take_bits(16));
			exp[i] = model_word(bank, addr);
			push_word(ddr_word(cmd_of(softmc_pkg::CMD_READ_BITS, bank, addr)));
		end
		push_word(end_word());
		wait_idle();
		for (int i = 0; i < 4; i++) begin
			do @(negedge clk); while (rdback_fifo_empty);
			check_data(rdback_data, exp[i], "readback word");
			@(posedge clk);
			rdback_fifo_rden <= 1'b1;
			@(posedge clk);
			rdback_fifo_rden <= 1'b0;
		end
		@(negedge clk);
		check_bit(rdback_fifo_empty, 1'b1, "rdback_fifo_empty after draining");
	endtask

	task automatic queue_backpressure();
		logic first_full;
		logic last_full;
		push_word(wait_word(BP_LONG_WAIT));
		push_word(end_word()); // only this END stays queued during the long wait
		for (int i = 0; i < softmc_pkg::IQ_DEPTH - 1; i++)
			push_word(wait_word(BP_WAIT));
		@(posedge clk);
		app_en <= 1'b1;
		app_instr <= end_word();
		@(negedge clk);
		first_full = iq_full;
		last_full = iq_full;
		while (!app_ack) begin
			last_full = iq_full;
			@(negedge clk);
		end
		@(posedge clk);
		app_en <= 1'b0;
		do @(negedge clk); while (app_ack);
		check_bit(first_full, 1'b1, "iq_full when END offered");
		check_bit(last_full, 1'b0, "iq_full in cycle END accepted");
		wait_idle();
	endtask

	task automatic refresh_spacing();
		int base;
		int n;
		base = ref_cyc.size();
		repeat (5 * softmc_pkg::REF_INTERVAL) @(posedge clk);
		n = ref_cyc.size() - base;
		if (n < 4 || n > 5)
			abort_run($sformatf("[FAIL] %0t %0d refreshes in five intervals, expected 4 or 5",
				$time, n));
		for (int i = 1; i < ref_cyc.size(); i++) begin
			if (ref_cyc[i] - ref_cyc[i - 1] < softmc_pkg::REF_INTERVAL)
				abort_run($sformatf("[FAIL] %0t refreshes only %0d cycles apart", $time,
					ref_cyc[i] - ref_cyc[i - 1]));
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("watchdog expired, run did not finish within %0d cycles",
			WATCHDOG_CYCLES));
	end

	initial begin
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		idle_after_reset();
		command_order();
		wait_gap();
		read_back();
		queue_backpressure();
		refresh_spacing();
		@(negedge clk);
		if (dut0.chk0.any_fail) begin
			abort_run("an assertion in softmc_checker failed");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

// ==== tests/softmc_checker.sv ====
`timescale 1ns/10ps

module softmc_checker (
	input logic clk,
	input logic reset,
	input logic app_en,
	input logic app_ack,
	input logic dfi_cs_n,
	input logic dfi_rddata_en,
	input logic rdback_fifo_empty
);

	logic cs_fail = 1'b0;
	logic rden_fail = 1'b0;
	logic ack_fail = 1'b0;
	logic any_fail;

	assign any_fail = cs_fail | rden_fail | ack_fail; // set once any assertion fails

	// arbiter drives a command for one cycle only
	cs_single: assert property (@(posedge clk) disable iff (reset) !dfi_cs_n |=> dfi_cs_n)
		else begin
			$error("dfi_cs_n low in two consecutive cycles");
			cs_fail = 1'b1;
		end

	// returned read data lands in the readback FIFO
	rden_to_fifo: assert property (@(posedge clk) disable iff (reset)
		dfi_rddata_en |-> ##5 !rdback_fifo_empty)
		else begin
			$error("read data did not reach the readback FIFO");
			rden_fail = 1'b1;
		end

	ack_after_en: assert property (@(posedge clk) disable iff (reset)
		$rose(app_ack) |-> $past(app_en))
		else begin
			$error("app_ack rose while app_en was low");
			ack_fail = 1'b1;
		end

endmodule

bind softmc_top softmc_checker chk0 (
	.clk(clk),
	.reset(reset),
	.app_en(app_en),
	.app_ack(app_ack),
	.dfi_cs_n(dfi_cs_n),
	.dfi_rddata_en(dfi_rddata_en),
	.rdback_fifo_empty(rdback_fifo_empty)
);

// ==== design/softmc_top.sv ====
`timescale 1ns/10ps

module softmc_top (
	input logic clk,
	input logic reset,

	// host instruction port
	input logic app_en,
	output logic app_ack,
	input logic [31:0] app_instr,
	output logic iq_full,
	output logic processing_iseq,

	// DFI command pins
	output logic dfi_cs_n,
	output logic dfi_ras_n,
	output logic dfi_cas_n,
	output logic dfi_we_n,
	output logic [softmc_pkg::BANK_W-1:0] dfi_bank,
	output logic [softmc_pkg::ROW_W-1:0] dfi_address,

	// DFI read
	output logic dfi_rddata_en,
	input logic [softmc_pkg::DATA_W-1:0] dfi_rddata,
	input logic dfi_rddata_valid,

	// readback to host
	input logic rdback_fifo_rden,
	output logic [softmc_pkg::DATA_W-1:0] rdback_data,
	output logic rdback_fifo_empty
);

	softmc_pkg::instr_t iq_head;
	logic iq_pop;
	logic iq_seq_ready;
	softmc_pkg::ddr_cmd_t dfi_cmd;

	dfi_cmd_if exec_cmd ();
	dfi_cmd_if ref_cmd ();

	assign dfi_cs_n = dfi_cmd.cs_n;
	assign dfi_ras_n = dfi_cmd.ras_n;
	assign dfi_cas_n = dfi_cmd.cas_n;
	assign dfi_we_n = dfi_cmd.we_n;
	assign dfi_bank = dfi_cmd.bank;
	assign dfi_address = dfi_cmd.address;

	instr_queue i_iq (
		.clk(clk),
		.reset(reset),
		.app_en(app_en),
		.app_instr(app_instr),
		.app_ack(app_ack),
		.iq_full(iq_full),
		.pop(iq_pop),
		.head(iq_head),
		.seq_ready(iq_seq_ready)
	);

	iseq_executor i_exec (
		.clk(clk),
		.reset(reset),
		.seq_ready(iq_seq_ready),
		.head(iq_head),
		.pop(iq_pop),
		.processing_iseq(processing_iseq),
		.cmd(exec_cmd.requester)
	);

	refresh_engine i_ref (
		.clk(clk),
		.reset(reset),
		.cmd(ref_cmd.requester)
	);

	cmd_arbiter i_arb (
		.clk(clk),
		.reset(reset),
		.exec_cmd(exec_cmd.arbiter),
		.ref_cmd(ref_cmd.arbiter),
		.dfi_cmd(dfi_cmd),
		.dfi_rddata_en(dfi_rddata_en)
	);

	rdback_fifo i_rdback (
		.clk(clk),
		.reset(reset),
		.dfi_rddata(dfi_rddata),
		.dfi_rddata_valid(dfi_rddata_valid),
		.rdback_fifo_rden(rdback_fifo_rden),
		.rdback_data(rdback_data),
		.rdback_fifo_empty(rdback_fifo_empty)
	);

endmodule

// ==== design/rdback_fifo.sv ====
`timescale 1ns/10ps

module rdback_fifo (
	input logic clk,
	input logic reset,
	input logic [softmc_pkg::DATA_W-1:0] dfi_rddata,
	input logic dfi_rddata_valid,
	input logic rdback_fifo_rden,
	output logic [softmc_pkg::DATA_W-1:0] rdback_data,
	output logic rdback_fifo_empty
);

	logic [softmc_pkg::DATA_W-1:0] mem [softmc_pkg::RB_DEPTH];

	logic [softmc_pkg::RB_PTR_W-1:0] wr_ptr;
	logic [softmc_pkg::RB_PTR_W-1:0] rd_ptr;
	logic [softmc_pkg::RB_PTR_W:0] count;
	logic wr_en;
	logic rd_en;

	assign wr_en = dfi_rddata_valid && !count[softmc_pkg::RB_PTR_W]; // dropped when full
	assign rd_en = rdback_fifo_rden && !rdback_fifo_empty;
	assign rdback_fifo_empty = (count == '0);
	assign rdback_data = mem[rd_ptr]; // head word shows without a read

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= dfi_rddata;
	end

endmodule

// ==== design/cmd_arbiter.sv ====
`timescale 1ns/10ps

module cmd_arbiter (
	input logic clk,
	input logic reset,
	dfi_cmd_if.arbiter exec_cmd,
	dfi_cmd_if.arbiter ref_cmd,
	output softmc_pkg::ddr_cmd_t dfi_cmd,
	output logic dfi_rddata_en
);

	enum logic [1:0] {IDLE, ISSUE, ACK} state;

	logic owner_ref; // refresh engine holds the bus
	logic owner_req;

	assign owner_req = owner_ref ? ref_cmd.req : exec_cmd.req;
	assign exec_cmd.ack = (state == ACK) && !owner_ref;
	assign ref_cmd.ack = (state == ACK) && owner_ref;

	// read strobe lines up with the command on the pins
	assign dfi_rddata_en = ({dfi_cmd.cs_n, dfi_cmd.ras_n, dfi_cmd.cas_n, dfi_cmd.we_n}
		== softmc_pkg::CMD_READ_BITS);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			owner_ref <= 1'b0;
			dfi_cmd <= softmc_pkg::CMD_NOP;
		end else begin
			dfi_cmd <= softmc_pkg::CMD_NOP; // pins carry a command one cycle only
			case (state)
				IDLE: begin
					if (ref_cmd.req) begin // refresh wins a tie
						owner_ref <= 1'b1;
						dfi_cmd <= ref_cmd.cmd;
						state <= ISSUE;
					end else if (exec_cmd.req) begin
						owner_ref <= 1'b0;
						dfi_cmd <= exec_cmd.cmd;
						state <= ISSUE;
					end
				end
				ISSUE: state <= ACK;
				ACK: begin
					// ack held until the owner lets go
					if (!owner_req)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== design/refresh_engine.sv ====
`timescale 1ns/10ps

module refresh_engine (
	input logic clk,
	input logic reset,
	dfi_cmd_if.requester cmd
);

	logic [softmc_pkg::REF_CNT_W-1:0] timer;
	logic req_q;

	assign cmd.req = req_q;
	assign cmd.cmd = '{cs_n: softmc_pkg::CMD_REF_BITS[3],
		ras_n: softmc_pkg::CMD_REF_BITS[2],
		cas_n: softmc_pkg::CMD_REF_BITS[1],
		we_n: softmc_pkg::CMD_REF_BITS[0],
		bank: '0,
		address: '0};

	always_ff @(posedge clk) begin
		if (reset) begin
			timer <= '0;
			req_q <= 1'b0;
		end else if (req_q) begin
			if (cmd.ack) begin
				req_q <= 1'b0;
				timer <= '0; // next interval starts at the ack
			end
		end else if (timer == softmc_pkg::REF_LAST) begin
			if (!cmd.ack) // previous ack must be gone
				req_q <= 1'b1;
		end else begin
			timer <= timer + 1'b1;
		end
	end

endmodule

// ==== design/iseq_executor.sv ====
`timescale 1ns/10ps

module iseq_executor (
	input logic clk,
	input logic reset,
	input logic seq_ready,
	input softmc_pkg::instr_t head,
	output logic pop,
	output logic processing_iseq,
	dfi_cmd_if.requester cmd
);

	enum logic [2:0] {IDLE, FETCH, COMMAND, WAITING, RELEASE} state;

	logic [softmc_pkg::WAIT_W-1:0] wait_cnt;
	softmc_pkg::ddr_cmd_t cmd_q;

	assign pop = (state == FETCH); // head word consumed every fetch cycle
	assign processing_iseq = (state != IDLE);
	assign cmd.req = (state == COMMAND);
	assign cmd.cmd = cmd_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (seq_ready)
						state <= FETCH;
				end
				FETCH: begin
					case (head.ddr.op)
						softmc_pkg::INSTR_DDR: state <= COMMAND;
						softmc_pkg::INSTR_WAIT: begin
							wait_cnt <= head.wt.cycles;
							state <= WAITING;
						end
						softmc_pkg::INSTR_END: state <= IDLE;
						default: state <= FETCH; // unknown type is skipped
					endcase
				end
				COMMAND: begin
					if (cmd.ack)
						state <= RELEASE;
				end
				RELEASE: begin
					// instruction done once ack drops
					if (!cmd.ack)
						state <= FETCH;
				end
				WAITING: begin
					if (wait_cnt == '0)
						state <= FETCH;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// command fields from the ddr view of the word
	always_ff @(posedge clk) begin
		if (state == FETCH) begin
			cmd_q <= '{cs_n: head.ddr.cs_n,
				ras_n: head.ddr.ras_n,
				cas_n: head.ddr.cas_n,
				we_n: head.ddr.we_n,
				bank: head.ddr.bank,
				address: head.ddr.address};
		end
	end

endmodule

// ==== design/instr_queue.sv ====
`timescale 1ns/10ps

module instr_queue (
	input logic clk,
	input logic reset,
	input logic app_en,
	input softmc_pkg::instr_t app_instr,
	output logic app_ack,
	output logic iq_full,
	input logic pop,
	output softmc_pkg::instr_t head,
	output logic seq_ready
);

	softmc_pkg::instr_t mem [softmc_pkg::IQ_DEPTH];

	logic [softmc_pkg::IQ_PTR_W-1:0] wr_ptr;
	logic [softmc_pkg::IQ_PTR_W-1:0] rd_ptr;
	logic [softmc_pkg::IQ_PTR_W:0] count;
	logic [softmc_pkg::IQ_PTR_W:0] end_cnt; // closed sequences waiting
	logic push;
	logic do_pop;
	logic end_in;
	logic end_out;

	assign iq_full = count[softmc_pkg::IQ_PTR_W]; // depth is a power of two
	assign push = app_en && !app_ack && !iq_full;
	assign do_pop = pop && (count != '0);
	assign head = mem[rd_ptr];

	assign end_in = push && (app_instr.ddr.op == softmc_pkg::INSTR_END);
	assign end_out = do_pop && (head.ddr.op == softmc_pkg::INSTR_END);
	assign seq_ready = (end_cnt != '0);

	// ack follows app_en one cycle later and stays low while full
	always_ff @(posedge clk) begin
		if (reset) begin
			app_ack <= 1'b0;
		end else if (push) begin
			app_ack <= 1'b1;
		end else if (!app_en) begin
			app_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			end_cnt <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({end_in, end_out})
				2'b10: end_cnt <= end_cnt + 1'b1;
				2'b01: end_cnt <= end_cnt - 1'b1;
				default: end_cnt <= end_cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= app_instr;
	end

endmodule

// ==== design/dfi_cmd_if.sv ====
`timescale 1ns/10ps

// one four-phase req/ack command request toward the arbiter
interface dfi_cmd_if;

	logic req;
	logic ack;
	softmc_pkg::ddr_cmd_t cmd; // held stable while req is high

	modport requester (
		output req,
		output cmd,
		input ack
	);

	modport arbiter (
		input req,
		input cmd,
		output ack
	);

endinterface

// ==== design/softmc_pkg.sv ====
package softmc_pkg;

	localparam int ROW_W = 16;
	localparam int BANK_W = 3;
	localparam int DATA_W = 64;
	localparam int WAIT_W = 28;

	localparam int IQ_DEPTH = 16;
	localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
	localparam int RB_DEPTH = 8;
	localparam int RB_PTR_W = $clog2(RB_DEPTH);

	localparam int REF_INTERVAL = 400; // cycles between refreshes
	localparam int REF_CNT_W = $clog2(REF_INTERVAL);
	localparam logic [REF_CNT_W-1:0] REF_LAST = REF_CNT_W'(REF_INTERVAL - 1);

	// instruction type field
	localparam logic [3:0] INSTR_DDR = 4'h1;
	localparam logic [3:0] INSTR_WAIT = 4'h2;
	localparam logic [3:0] INSTR_END = 4'h4;

	typedef struct packed {
		logic [3:0] op;
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [BANK_W-1:0] bank;
		logic [4:0] spare;
		logic [ROW_W-1:0] address;
	} instr_ddr_t;

	typedef struct packed {
		logic [3:0] op;
		logic [WAIT_W-1:0] cycles;
	} instr_wait_t;

	// one 32-bit host word as raw command or wait
	typedef union packed {
		instr_ddr_t ddr;
		instr_wait_t wt;
	} instr_t;

	typedef struct packed {
		logic cs_n;
		logic ras_n;
		logic cas_n;
		logic we_n;
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0] address;
	} ddr_cmd_t;

	localparam ddr_cmd_t CMD_NOP = '{cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
		bank: '0, address: '0};

	// {cs_n, ras_n, cas_n, we_n}
	localparam logic [3:0] CMD_REF_BITS = 4'b0001;
	localparam logic [3:0] CMD_READ_BITS = 4'b0101;

endpackage
